//--- source/mips_pkg.sv
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int NB_WORD     = 32;                  // Data and instruction word
    localparam int NB_OPCODE   = 6;                   // Opcode and function field
    localparam int NB_REG      = 5;                   // Register index
    localparam int NB_IMM      = 16;                  // Raw immediate
    localparam int NB_ALU_CODE = 4;
    localparam int NB_ALU_OP   = 2;
    localparam int MEM_DEPTH   = 64;                  // Data words
    localparam int NB_MEM_ADDR = $clog2(MEM_DEPTH);   // Word address bits

    typedef logic [NB_WORD-1:0] word_t;
    typedef logic [NB_REG-1:0]  reg_idx_t;

    // ALU operation codes
    typedef enum logic [NB_ALU_CODE-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_SLLV = 4'd10,
        ALU_SRLV = 4'd11,
        ALU_SRAV = 4'd12,
        ALU_LUI  = 4'd13
    } alu_code_t;

    // Class handed from the decoder to the ALU control
    typedef enum logic [NB_ALU_OP-1:0] {
        ALU_OP_ADD   = 2'b00,   // Address and ADDI
        ALU_OP_RTYPE = 2'b10,   // By function field
        ALU_OP_IMM   = 2'b11    // Immediate logic by opcode
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Control fields
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;      // Write back load data instead of ALU result
    } ctrl_wb_t;

    typedef struct packed {
        logic spare;
        logic sb;
        logic sh;
        logic lb;
        logic lh;
        logic unsigned_ld;     // Zero extend loaded byte or half
        logic mem_read;
        logic mem_write;
    } ctrl_mem_t;

    typedef struct packed {
        logic      reg_dst;    // Destination rd
        logic      alu_src1;   // Operand A from shamt
        logic      alu_src2;   // Operand B from immediate
        alu_code_t alu_code;
    } ctrl_ex_t;

    // Opcodes
    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'b000000;
    localparam logic [NB_OPCODE-1:0] OP_LB    = 6'b100000;
    localparam logic [NB_OPCODE-1:0] OP_LH    = 6'b100001;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'b100011;
    localparam logic [NB_OPCODE-1:0] OP_LBU   = 6'b100100;
    localparam logic [NB_OPCODE-1:0] OP_LHU   = 6'b100101;
    localparam logic [NB_OPCODE-1:0] OP_SB    = 6'b101000;
    localparam logic [NB_OPCODE-1:0] OP_SH    = 6'b101001;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'b101011;
    localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'b001000;
    localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'b001100;
    localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'b001101;
    localparam logic [NB_OPCODE-1:0] OP_XORI  = 6'b001110;
    localparam logic [NB_OPCODE-1:0] OP_LUI   = 6'b001111;

    // Function field of R-type
    localparam logic [NB_OPCODE-1:0] FN_ADD  = 6'b100000;
    localparam logic [NB_OPCODE-1:0] FN_SUB  = 6'b100010;
    localparam logic [NB_OPCODE-1:0] FN_AND  = 6'b100100;
    localparam logic [NB_OPCODE-1:0] FN_OR   = 6'b100101;
    localparam logic [NB_OPCODE-1:0] FN_XOR  = 6'b100110;
    localparam logic [NB_OPCODE-1:0] FN_NOR  = 6'b100111;
    localparam logic [NB_OPCODE-1:0] FN_SLT  = 6'b101010;
    localparam logic [NB_OPCODE-1:0] FN_SLL  = 6'b000000;
    localparam logic [NB_OPCODE-1:0] FN_SRL  = 6'b000010;
    localparam logic [NB_OPCODE-1:0] FN_SRA  = 6'b000011;
    localparam logic [NB_OPCODE-1:0] FN_SLLV = 6'b000100;
    localparam logic [NB_OPCODE-1:0] FN_SRLV = 6'b000110;
    localparam logic [NB_OPCODE-1:0] FN_SRAV = 6'b000111;

    // Fixed control words per instruction kind
    localparam ctrl_wb_t  WB_NONE  = 2'b00;
    localparam ctrl_wb_t  WB_ALU   = 2'b10;
    localparam ctrl_wb_t  WB_LOAD  = 2'b11;
    localparam ctrl_mem_t MEM_NONE = 8'b0000_0000;
    localparam ctrl_mem_t MEM_LB   = 8'b0001_0010;
    localparam ctrl_mem_t MEM_LH   = 8'b0000_1010;
    localparam ctrl_mem_t MEM_LW   = 8'b0000_0010;
    localparam ctrl_mem_t MEM_LBU  = 8'b0001_0110;
    localparam ctrl_mem_t MEM_LHU  = 8'b0000_1110;
    localparam ctrl_mem_t MEM_SB   = 8'b0100_0001;
    localparam ctrl_mem_t MEM_SH   = 8'b0010_0001;
    localparam ctrl_mem_t MEM_SW   = 8'b0000_0001;

endpackage

`default_nettype wire

//--- source/pipe_if.sv
`timescale 1ns/1ns
`default_nettype none

// Decode to execute stage register
interface id_ex_if;
    import mips_pkg::*;

    logic      valid;
    ctrl_wb_t  ctrl_wb;
    ctrl_mem_t ctrl_mem;
    ctrl_ex_t  ctrl_ex;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm_ext;      // Already extended
    reg_idx_t  shamt;
    reg_idx_t  rt;
    reg_idx_t  rd;

    modport producer (output valid, ctrl_wb, ctrl_mem, ctrl_ex,
                      output rs_data, rt_data, imm_ext, shamt, rt, rd);
    modport consumer (input  valid, ctrl_wb, ctrl_mem, ctrl_ex,
                      input  rs_data, rt_data, imm_ext, shamt, rt, rd);
endinterface

// Execute to result stage register
interface ex_res_if;
    import mips_pkg::*;

    logic      valid;
    ctrl_wb_t  ctrl_wb;
    ctrl_mem_t ctrl_mem;
    word_t     alu_result;   // Also the memory byte address
    word_t     store_data;
    reg_idx_t  dest;

    modport producer (output valid, ctrl_wb, ctrl_mem, alu_result, store_data, dest);
    modport consumer (input  valid, ctrl_wb, ctrl_mem, alu_result, store_data, dest);
endinterface

`default_nettype wire

//--- source/alu_control.sv
`timescale 1ns/1ns
`default_nettype none

module alu_control
(
    input  wire logic [mips_pkg::NB_OPCODE-1:0] i_funct,
    input  wire logic [mips_pkg::NB_OPCODE-1:0] i_opcode,
    input  wire mips_pkg::alu_op_t              i_alu_op,
    output mips_pkg::alu_code_t                 o_alu_code
);
    import mips_pkg::*;

    always_comb
    begin
        o_alu_code = ALU_ADD;                   // Loads, stores, ADDI
        case (i_alu_op)
            ALU_OP_RTYPE:
            begin
                case (i_funct)
                    FN_ADD:  o_alu_code = ALU_ADD;
                    FN_SUB:  o_alu_code = ALU_SUB;
                    FN_AND:  o_alu_code = ALU_AND;
                    FN_OR:   o_alu_code = ALU_OR;
                    FN_XOR:  o_alu_code = ALU_XOR;
                    FN_NOR:  o_alu_code = ALU_NOR;
                    FN_SLT:  o_alu_code = ALU_SLT;
                    FN_SLL:  o_alu_code = ALU_SLL;
                    FN_SRL:  o_alu_code = ALU_SRL;
                    FN_SRA:  o_alu_code = ALU_SRA;
                    FN_SLLV: o_alu_code = ALU_SLLV;
                    FN_SRLV: o_alu_code = ALU_SRLV;
                    FN_SRAV: o_alu_code = ALU_SRAV;
                    default: o_alu_code = ALU_ADD;  // Unknown function
                endcase
            end
            ALU_OP_IMM:
            begin
                // Immediate logic picks by opcode
                case (i_opcode)
                    OP_ANDI: o_alu_code = ALU_AND;
                    OP_ORI:  o_alu_code = ALU_OR;
                    OP_XORI: o_alu_code = ALU_XOR;
                    OP_LUI:  o_alu_code = ALU_LUI;
                    default: o_alu_code = ALU_ADD;
                endcase
            end
            default: o_alu_code = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

//--- source/control_decode.sv
`timescale 1ns/1ns
`default_nettype none

module control_decode
(
    input  wire logic            i_clk,
    input  wire logic            i_rst_n,
    input  wire logic            i_valid,
    input  wire mips_pkg::word_t i_instr,
    input  wire mips_pkg::word_t i_rs_data,
    input  wire mips_pkg::word_t i_rt_data,
    id_ex_if.producer            o_id_ex
);
    import mips_pkg::*;

    logic [NB_OPCODE-1:0] opcode;
    logic [NB_OPCODE-1:0] funct;
    logic [NB_IMM-1:0]    imm;
    reg_idx_t             rt;
    reg_idx_t             rd;
    reg_idx_t             shamt;
    alu_op_t              alu_op;
    alu_code_t            alu_code;
    ctrl_wb_t             dec_wb;
    ctrl_mem_t            dec_mem;
    ctrl_ex_t             dec_ex;
    logic                 zero_ext;
    word_t                imm_ext;

    // Instruction fields
    assign opcode = i_instr[31:26];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign shamt  = i_instr[10:6];
    assign funct  = i_instr[5:0];
    assign imm    = i_instr[NB_IMM-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decoder
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        alu_op          = ALU_OP_ADD;
        dec_wb          = WB_NONE;        // Unknown opcode is a no-op
        dec_ex          = '0;
        case (opcode)
            OP_RTYPE:
            begin
                alu_op          = ALU_OP_RTYPE;
                dec_wb          = WB_ALU;
                dec_ex.reg_dst  = 1'b1;
                dec_ex.alu_src1 = (funct == FN_SLL) || (funct == FN_SRL)
                                  || (funct == FN_SRA);  // Shift by shamt
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
            begin
                dec_wb          = WB_LOAD;
                dec_ex.alu_src2 = 1'b1;   // Base plus offset
            end
            OP_SB, OP_SH, OP_SW:
            begin
                dec_ex.alu_src2 = 1'b1;   // No write back
            end
            OP_ADDI:
            begin
                dec_wb          = WB_ALU;
                dec_ex.alu_src2 = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                alu_op          = ALU_OP_IMM;
                dec_wb          = WB_ALU;
                dec_ex.alu_src2 = 1'b1;
            end
            default: ;
        endcase
        dec_ex.alu_code = alu_code;
    end

    // Memory lanes and extension per load or store
    always_comb
    begin
        case (opcode)
            OP_LB:   dec_mem = MEM_LB;
            OP_LH:   dec_mem = MEM_LH;
            OP_LW:   dec_mem = MEM_LW;
            OP_LBU:  dec_mem = MEM_LBU;
            OP_LHU:  dec_mem = MEM_LHU;
            OP_SB:   dec_mem = MEM_SB;
            OP_SH:   dec_mem = MEM_SH;
            OP_SW:   dec_mem = MEM_SW;
            default: dec_mem = MEM_NONE;
        endcase
    end

    alu_control u_alu_control
    (
        .i_funct    (funct),
        .i_opcode   (opcode),
        .i_alu_op   (alu_op),
        .o_alu_code (alu_code)
    );

    // Logical immediates zero extend and all others sign extend
    assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign imm_ext  = zero_ext ? {{(NB_WORD-NB_IMM){1'b0}}, imm}
                               : {{(NB_WORD-NB_IMM){imm[NB_IMM-1]}}, imm};

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_id_ex.valid    <= 1'b0;
            o_id_ex.ctrl_wb  <= '0;
            o_id_ex.ctrl_mem <= '0;
            o_id_ex.ctrl_ex  <= '0;
        end
        else
        begin
            o_id_ex.valid    <= i_valid;
            o_id_ex.ctrl_wb  <= i_valid ? dec_wb  : '0;   // Idle slot carries zero control
            o_id_ex.ctrl_mem <= i_valid ? dec_mem : '0;
            o_id_ex.ctrl_ex  <= i_valid ? dec_ex  : '0;
        end
    end

    // Payload
    always_ff @(posedge i_clk)
    begin
        o_id_ex.rs_data <= i_rs_data;
        o_id_ex.rt_data <= i_rt_data;
        o_id_ex.imm_ext <= imm_ext;
        o_id_ex.shamt   <= shamt;
        o_id_ex.rt      <= rt;
        o_id_ex.rd      <= rd;
    end

    // A live instruction never both reads and writes memory
    a_no_rd_and_wr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |=> !(o_id_ex.ctrl_mem.mem_read && o_id_ex.ctrl_mem.mem_write));

endmodule

`default_nettype wire

//--- source/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    id_ex_if.consumer  i_id_ex,
    ex_res_if.producer o_ex_res
);
    import mips_pkg::*;

    word_t    op_a;
    word_t    op_b;
    word_t    alu_res;
    reg_idx_t dest;
    logic [4:0] sh_amt;

    ////////////////////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////////////////////
    assign op_a   = i_id_ex.ctrl_ex.alu_src1 ? {{(NB_WORD-NB_REG){1'b0}}, i_id_ex.shamt}
                                             : i_id_ex.rs_data;
    assign op_b   = i_id_ex.ctrl_ex.alu_src2 ? i_id_ex.imm_ext : i_id_ex.rt_data;
    assign sh_amt = op_a[4:0];              // Shamt or low bits of rs

    // ALU
    always_comb
    begin
        case (i_id_ex.ctrl_ex.alu_code)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_NOR:  alu_res = ~(op_a | op_b);
            ALU_SLT:  alu_res = word_t'($signed(op_a) < $signed(op_b));   // Signed compare
            ALU_SLL,
            ALU_SLLV: alu_res = op_b << sh_amt;
            ALU_SRL,
            ALU_SRLV: alu_res = op_b >> sh_amt;
            ALU_SRA,
            ALU_SRAV: alu_res = word_t'($signed(op_b) >>> sh_amt);        // Keeps the sign
            ALU_LUI:  alu_res = {op_b[NB_IMM-1:0], {NB_IMM{1'b0}}};
            default:  alu_res = op_a + op_b;
        endcase
    end

    assign dest = i_id_ex.ctrl_ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;   // rd for R-type

    ////////////////////////////////////////////////////////////////////////////
    // EX/result register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ex_res.valid    <= 1'b0;
            o_ex_res.ctrl_wb  <= '0;
            o_ex_res.ctrl_mem <= '0;
        end
        else
        begin
            o_ex_res.valid    <= i_id_ex.valid;
            o_ex_res.ctrl_wb  <= i_id_ex.ctrl_wb;    // Already zero in idle slots
            o_ex_res.ctrl_mem <= i_id_ex.ctrl_mem;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_ex_res.alu_result <= alu_res;
        o_ex_res.store_data <= i_id_ex.rt_data;   // Store data is rt as read
        o_ex_res.dest       <= dest;
    end

    // Decoder never asks for shamt and immediate at once
    a_one_src: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_id_ex.valid |-> !(i_id_ex.ctrl_ex.alu_src1 && i_id_ex.ctrl_ex.alu_src2));

endmodule

`default_nettype wire

//--- source/mem_result.sv
`timescale 1ns/1ns
`default_nettype none

module mem_result
(
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    ex_res_if.consumer  i_ex_res,
    output logic               o_wb_valid,
    output mips_pkg::reg_idx_t o_wb_reg,
    output mips_pkg::word_t    o_wb_data
);
    import mips_pkg::*;

    word_t                  mem [MEM_DEPTH];   // Data memory
    logic [NB_MEM_ADDR-1:0] word_addr;
    logic [1:0]             lane;
    word_t                  rd_word;
    logic [7:0]             rd_byte;
    logic [15:0]            rd_half;
    word_t                  ld_data;

    assign word_addr = i_ex_res.alu_result[NB_MEM_ADDR+1:2];
    assign lane      = i_ex_res.alu_result[1:0];   // Little-endian byte lane

    ////////////////////////////////////////////////////////////////////////////
    // Store with lane write
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_ex_res.valid && i_ex_res.ctrl_mem.mem_write)
        begin
            if (i_ex_res.ctrl_mem.sb)
                mem[word_addr][8*lane +: 8] <= i_ex_res.store_data[7:0];
            else if (i_ex_res.ctrl_mem.sh)
                mem[word_addr][16*lane[1] +: 16] <= i_ex_res.store_data[15:0];
            else
                mem[word_addr] <= i_ex_res.store_data;   // SW
        end
    end

    // Load path
    assign rd_word = mem[word_addr];
    assign rd_byte = rd_word[8*lane +: 8];
    assign rd_half = rd_word[16*lane[1] +: 16];   // Bit 1 picks the half

    always_comb
    begin
        if (i_ex_res.ctrl_mem.lb)
            ld_data = i_ex_res.ctrl_mem.unsigned_ld ? {24'b0, rd_byte}
                                                    : {{24{rd_byte[7]}}, rd_byte};
        else if (i_ex_res.ctrl_mem.lh)
            ld_data = i_ex_res.ctrl_mem.unsigned_ld ? {16'b0, rd_half}
                                                    : {{16{rd_half[15]}}, rd_half};
        else
            ld_data = rd_word;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_wb_valid <= 1'b0;
        else
            o_wb_valid <= i_ex_res.valid && i_ex_res.ctrl_wb.reg_write;   // Stores stay silent
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_reg  <= i_ex_res.dest;   // r0 reported as is
        o_wb_data <= i_ex_res.ctrl_wb.mem_to_reg ? ld_data : i_ex_res.alu_result;
    end

    // Halfword accesses are aligned
    a_half_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ex_res.valid && (i_ex_res.ctrl_mem.mem_read || i_ex_res.ctrl_mem.mem_write)
         && (i_ex_res.ctrl_mem.sh || i_ex_res.ctrl_mem.lh))
        |-> !i_ex_res.alu_result[0]);

endmodule

`default_nettype wire

//--- source/mips_slice_top.sv
`timescale 1ns/1ns
`default_nettype none

module mips_slice_top
(
    input  wire logic            i_clk,
    input  wire logic            i_rst_n,
    input  wire logic            i_valid,       // Instruction strobe
    input  wire mips_pkg::word_t i_instr,
    input  wire mips_pkg::word_t i_rs_data,     // Register values read by caller
    input  wire mips_pkg::word_t i_rt_data,
    output logic                 o_wb_valid,
    output mips_pkg::reg_idx_t   o_wb_reg,
    output mips_pkg::word_t      o_wb_data
);

    // Stage registers
    id_ex_if  id_ex_bus ();
    ex_res_if ex_res_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Decode, execute, result
    ////////////////////////////////////////////////////////////////////////////
    control_decode u_control_decode
    (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_rs_data (i_rs_data),
        .i_rt_data (i_rt_data),
        .o_id_ex   (id_ex_bus.producer)
    );

    alu_execute u_alu_execute
    (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_id_ex  (id_ex_bus.consumer),
        .o_ex_res (ex_res_bus.producer)
    );

    mem_result u_mem_result
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ex_res   (ex_res_bus.consumer),
        .o_wb_valid (o_wb_valid),
        .o_wb_reg   (o_wb_reg),
        .o_wb_data  (o_wb_data)
    );

endmodule

`default_nettype wire

//--- sim/tb_mips_slice.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_slice;
    import mips_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int RESET_LIMIT  = 10;   // Cycles allowed for the pipeline to come up idle
    localparam int DRAIN_LIMIT  = 8;
    localparam int LATENCY      = 3;    // Input edge to write-back edge

    logic     clk;
    logic     rst_n;
    logic     valid;
    word_t    instr;
    word_t    rs_data;
    word_t    rt_data;
    logic     wb_valid;
    reg_idx_t wb_reg;
    word_t    wb_data;

    // Vector table as read from the file
    logic     vec_valid [$];
    word_t    vec_instr [$];
    word_t    vec_rs    [$];
    word_t    vec_rt    [$];
    logic     vec_wb    [$];
    reg_idx_t vec_reg   [$];
    word_t    vec_data  [$];

    // Expectations of the slots in flight with the oldest first
    logic     exp_wb   [$];
    reg_idx_t exp_reg  [$];
    word_t    exp_data [$];
    int       checked;

    mips_slice_top i_mips_slice_top
    (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_valid    (valid),
        .i_instr    (instr),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .o_wb_valid (wb_valid),
        .o_wb_reg   (wb_reg),
        .o_wb_data  (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure and compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_failure($sformatf("ERROR: %s expected 0x%h got 0x%h", name, exp, act));
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp)
            report_failure($sformatf("ERROR: %s expected 0x%h got 0x%h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("ERROR: %s expected 0x%h got 0x%h", name, exp, act));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Vector file, driver and monitor
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        word_t f_valid;
        word_t f_instr;
        word_t f_rs;
        word_t f_rt;
        word_t f_wb;
        word_t f_reg;
        word_t f_data;
        fd = $fopen("sim/mips_vectors.txt", "r");
        if (fd == 0)
            report_failure("Could not open the vector file sim/mips_vectors.txt");
        while (!$feof(fd))
        begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#")   // Skip column notes
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f_valid, f_instr, f_rs, f_rt, f_wb, f_reg, f_data);
                if (n == 7)
                begin
                    vec_valid.push_back(f_valid[0]);
                    vec_instr.push_back(f_instr);
                    vec_rs.push_back(f_rs);
                    vec_rt.push_back(f_rt);
                    vec_wb.push_back(f_wb[0]);
                    vec_reg.push_back(f_reg[NB_REG-1:0]);
                    vec_data.push_back(f_data);
                end
                else if (n > 0)
                    report_failure("A vector line does not hold seven hex columns");
            end
        end
        $fclose(fd);
        if (vec_instr.size() == 0)
            report_failure("The vector file holds no vectors");
    endtask

    // One slot per cycle with its expectation queued
    task automatic drive_vector(input int idx);
        valid   = vec_valid[idx];
        instr   = vec_instr[idx];
        rs_data = vec_rs[idx];
        rt_data = vec_rt[idx];
        exp_wb.push_back(vec_wb[idx]);
        exp_reg.push_back(vec_reg[idx]);
        exp_data.push_back(vec_data[idx]);
    endtask

    task automatic drive_idle();
        valid   = 1'b0;
        instr   = '0;
        rs_data = '0;
        rt_data = '0;
    endtask

    // Oldest slot is due at the output now
    task automatic check_oldest();
        logic     wb;
        reg_idx_t r;
        word_t    d;
        wb = exp_wb.pop_front();
        r  = exp_reg.pop_front();
        d  = exp_data.pop_front();
        check_flag("o_wb_valid", wb, wb_valid);
        if (wb)
        begin
            check_reg("o_wb_reg", r, wb_reg);   // r0 reported raw
            check_word("o_wb_data", d, wb_data);
        end
        checked++;
    endtask

    initial
    begin : main
        int cnt;
        rst_n   = 1'b0;
        checked = 0;
        drive_idle();
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Pipeline must come out of reset idle
        cnt = 0;
        while (wb_valid !== 1'b0 && cnt < RESET_LIMIT)
        begin
            @(posedge clk);
            cnt++;
        end
        if (wb_valid !== 1'b0)
            report_failure("Write-back valid did not settle low after reset release");

        for (int i = 0; i < vec_instr.size(); i++)
        begin
            @(posedge clk);
            #1;                                 // Outputs settled and inputs change here
            if (exp_wb.size() == LATENCY)
                check_oldest();
            drive_vector(i);
        end

        // Drain the slots still in flight
        cnt = 0;
        while (exp_wb.size() > 0 && cnt < DRAIN_LIMIT)
        begin
            @(posedge clk);
            #1;
            check_oldest();
            drive_idle();
            cnt++;
        end
        if (exp_wb.size() > 0)
            report_failure("The pipeline did not drain within the cycle limit");
        else
        begin
            $display("%0d slots checked", checked);
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/mips_vectors.txt
# valid instr rs_data rt_data wb reg wb_data, all hex
# wb 0 for stores, idle slots and unknown opcodes; reg and wb_data are then ignored
# R-type arithmetic and logic
1 00221820 00000005 00000003 1 03 00000008
1 00222022 00000003 00000005 1 04 fffffffe
1 00222824 f0f0f0f0 ff00ff00 1 05 f000f000
1 00223025 f0f0f0f0 0f0f0000 1 06 fffff0f0
1 00223826 ffff0000 0f0f0f0f 1 07 f0f00f0f
1 00224027 00ff00ff 0000ffff 1 08 ff000000
1 0022482a fffffffb 00000002 1 09 00000001
1 0022502a 00000002 fffffffe 1 0a 00000000
# Shifts by shamt and by rs
1 00225900 deadbeef 000000f1 1 0b 00000f10
1 00226202 00000000 80000000 1 0c 00800000
1 00226a03 00000000 80000000 1 0d ff800000
1 00227004 00000024 0000000f 1 0e 000000f0
1 00227806 00000003 f0000000 1 0f 1e000000
1 00228007 0000003c 80000000 1 10 fffffff8
# Immediates write rt
1 2031fffc 00000010 00000000 1 11 0000000c
1 3032f0f0 ffffffff 00000000 1 12 0000f0f0
1 34338001 12340000 00000000 1 13 12348001
1 3834ffff ffff1234 00000000 1 14 ffffedcb
1 3c15abcd 00000000 00000000 1 15 abcd0000
# Stores to words at 0x40 and 0x44, then loads
1 ac220000 00000040 11223344 0 00 00000000
1 ac220004 00000040 55667788 0 00 00000000
1 a4220002 00000040 0000beef 0 00 00000000
1 a0220005 00000040 000000a5 0 00 00000000
1 8c230000 00000040 00000000 1 03 beef3344
1 8c240004 00000040 00000000 1 04 5566a588
1 84250002 00000040 00000000 1 05 ffffbeef
1 94260002 00000040 00000000 1 06 0000beef
1 80270005 00000040 00000000 1 07 ffffffa5
1 90280005 00000040 00000000 1 08 000000a5
1 84290000 00000040 00000000 1 09 00003344
1 802a0006 00000040 00000000 1 0a 00000066
1 802bffff 00000048 00000000 1 0b 00000055
# Back to back with idle slots and unknown opcodes
0 00000000 00000000 00000000 0 00 00000000
1 00220820 7fffffff 00000001 1 01 80000000
1 fc221234 00000001 00000002 0 00 00000000
0 00000000 00000000 00000000 0 00 00000000
0 00000000 00000000 00000000 0 00 00000000
1 20200001 00000041 00000000 1 00 00000042
1 0022f822 00000000 00000001 1 1f ffffffff
1 f8000000 00000000 00000000 0 00 00000000
1 00221025 00000000 00000000 1 02 00000000
0 00000000 00000000 00000000 0 00 00000000

//--- verilog.f
source/mips_pkg.sv
source/pipe_if.sv
source/alu_control.sv
source/control_decode.sv
source/alu_execute.sv
source/mem_result.sv
source/mips_slice_top.sv
sim/tb_mips_slice.sv
